/* files.f */
rtl/lspPkg.sv
rtl/basicOps.sv
rtl/lspBufferRam.sv
rtl/lspExpand.sv
rtl/busArbiter.sv
rtl/axiLiteRegs.sv
rtl/lspExpandTop.sv
verification/lspExpandTb.sv

/* rtl/axiLiteRegs.sv */
`default_nettype none

module axiLiteRegs (
	input wire clk,
	input wire reset,
	// AXI4-Lite slave
	input wire [6:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [31:0] wdata,
	input wire [3:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [6:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,
	// Engine control
	output logic startLow,
	output logic startHigh,
	output logic startFull,
	input wire doneLow,
	input wire doneHigh,
	input wire doneFull,
	output logic [lspPkg::coefWidth-1:0] gap,
	// Arbitrated buffer port
	output logic request,
	input wire grant,
	output logic [lspPkg::bufAddrWidth-1:0] memReadAddr,
	output logic [lspPkg::bufAddrWidth-1:0] memWriteAddr,
	output logic [lspPkg::coefWidth-1:0] memOut,
	output logic memWriteEn,
	input wire [lspPkg::coefWidth-1:0] memIn
);

	import lspPkg::*;

	logic [6:0] wrOffset, rdOffset;	// Relative to the buffer window
	logic wrIsBuf, rdIsBuf;
	logic wrWant, rdWant;
	logic wrFire, arFire;
	logic rdCapture;	// RAM data due this cycle
	logic [numMasters-1:masterLow] startHit, startPulse, statusClear;
	logic [numMasters-1:masterLow] busyFlags, doneFlags, doneVec;
	logic [31:0] regValue;

	//////////////////////////////
	// Address decode and handshakes

	assign wrOffset = awaddr - regBufBase;
	assign rdOffset = araddr - regBufBase;
	assign wrIsBuf = wrOffset < 7'(bufDepth * 4);
	assign rdIsBuf = rdOffset < 7'(bufDepth * 4);

	// Buffer accesses go through the arbiter, registers never wait
	assign wrWant = awvalid && wvalid && !bvalid && wrIsBuf;
	assign rdWant = arvalid && !rvalid && !rdCapture && rdIsBuf;
	assign request = wrWant || rdWant || rdCapture;

	assign wrFire = awvalid && wvalid && !bvalid && (!wrIsBuf || grant);
	assign arFire = arvalid && !rvalid && !rdCapture && (!rdIsBuf || grant);
	assign awready = wrFire;
	assign wready = wrFire;
	assign arready = arFire;
	assign bresp = 2'b00;	// OKAY
	assign rresp = 2'b00;

	// Buffer window, blocked by the arbiter unless granted
	assign memReadAddr = rdOffset[bufAddrWidth+1:2];
	assign memWriteAddr = wrOffset[bufAddrWidth+1:2];
	assign memOut = wdata[coefWidth-1:0];
	assign memWriteEn = wrFire && wrIsBuf && |wstrb[1:0];

	//////////////////////////////
	// Control and status

	assign doneVec[masterLow] = doneLow;
	assign doneVec[masterHigh] = doneHigh;
	assign doneVec[masterFull] = doneFull;
	assign startLow = startPulse[masterLow];
	assign startHigh = startPulse[masterHigh];
	assign startFull = startPulse[masterFull];

	// Running engines ignore a second start
	assign startHit = (wrFire && awaddr == regControl && wstrb[0]) ?
		wdata[numMasters-1:masterLow] & ~busyFlags : '0;
	assign statusClear = (wrFire && awaddr == regStatus && wstrb[0]) ?
		wdata[numMasters-1:masterLow] : '0;

	always_comb
	begin
		regValue = '0;	// Control and unmapped read zero
		case (araddr)
			regGap:
				regValue[coefWidth-1:0] = gap;
			regStatus:
			begin
				regValue[numMasters-1:masterLow] = doneFlags;	// Bits 3:1
				regValue[2*numMasters-1:numMasters+masterLow] = busyFlags;	// Bits 7:5
			end
			default:
				regValue = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			rdCapture <= 1'b0;
			startPulse <= '0;
			busyFlags <= '0;
			doneFlags <= '0;
			gap <= defaultGap;
		end
		else
		begin
			rdCapture <= arFire && rdIsBuf;
			startPulse <= startHit;
			busyFlags <= (busyFlags | startHit) & ~doneVec;
			doneFlags <= (doneFlags & ~statusClear) | doneVec;	// Set beats clear
			if (wrFire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if ((arFire && !rdIsBuf) || rdCapture)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (wrFire && awaddr == regGap)
			begin
				if (wstrb[0])
					gap[7:0] <= wdata[7:0];
				if (wstrb[1])
					gap[15:8] <= wdata[15:8];
			end
		end
	end

	// Read data holds until the next capture
	always_ff @(posedge clk)
	begin
		if (arFire && !rdIsBuf)
			rdata <= regValue;
		else if (rdCapture)
			rdata <= 32'(memIn);
	end

endmodule

`default_nettype wire

/* rtl/basicOps.sv */
`default_nettype none

module basicOps (
	input wire [15:0] subA,
	input wire [15:0] subB,
	input wire [15:0] addA,
	input wire [15:0] addB,
	input wire [15:0] shrVar1,
	input wire [15:0] shrVar2,
	input wire [31:0] lSubA,
	input wire [31:0] lSubB,
	input wire [31:0] lAddA,
	input wire [31:0] lAddB,
	output logic [15:0] subResult,
	output logic [15:0] addResult,
	output logic [15:0] shrResult,
	output logic [31:0] lSubResult,
	output logic [31:0] lAddResult
);

	logic [16:0] subWide;	// One guard bit above the sign
	logic [16:0] addWide;
	logic [32:0] lSubWide;
	logic [32:0] lAddWide;
	logic [3:0] shrCount;

	// Sign-extended raw results
	assign subWide = {subA[15], subA} - {subB[15], subB};
	assign addWide = {addA[15], addA} + {addB[15], addB};
	assign lSubWide = {lSubA[31], lSubA} - {lSubB[31], lSubB};
	assign lAddWide = {lAddA[31], lAddA} + {lAddB[31], lAddB};

	// Guard and sign disagree means overflow, clamp toward the guard's sign
	assign subResult = (subWide[16] != subWide[15]) ?
		{subWide[16], {15{~subWide[16]}}} : subWide[15:0];	// 0x8000 or 0x7fff
	assign addResult = (addWide[16] != addWide[15]) ?
		{addWide[16], {15{~addWide[16]}}} : addWide[15:0];
	assign lSubResult = (lSubWide[32] != lSubWide[31]) ?
		{lSubWide[32], {31{~lSubWide[32]}}} : lSubWide[31:0];
	assign lAddResult = (lAddWide[32] != lAddWide[31]) ?
		{lAddWide[32], {31{~lAddWide[32]}}} : lAddWide[31:0];

	// Count clamped to 15, negative counts leave var1 as is
	assign shrCount = shrVar2[15] ? 4'd0 :
		(shrVar2 > 16'd15) ? 4'd15 : shrVar2[3:0];
	assign shrResult = $signed(shrVar1) >>> shrCount;	// Sign fill

endmodule

`default_nettype wire

/* rtl/busArbiter.sv */
`default_nettype none

module busArbiter (
	input wire clk,
	input wire reset,
	input wire [lspPkg::numMasters-1:0] request,
	output logic [lspPkg::numMasters-1:0] grant,
	// Per-master RAM side, master 0 is the AXI slave
	input wire [lspPkg::numMasters-1:0][lspPkg::bufAddrWidth-1:0] memReadAddr,
	input wire [lspPkg::numMasters-1:0][lspPkg::bufAddrWidth-1:0] memWriteAddr,
	input wire [lspPkg::numMasters-1:0][lspPkg::coefWidth-1:0] memWriteData,
	input wire [lspPkg::numMasters-1:0] memWriteEn,
	// Per-engine operands
	input wire [lspPkg::numMasters-1:lspPkg::masterLow][15:0] subA, subB,
	input wire [lspPkg::numMasters-1:lspPkg::masterLow][15:0] addA, addB,
	input wire [lspPkg::numMasters-1:lspPkg::masterLow][15:0] shrVar1, shrVar2,
	input wire [lspPkg::numMasters-1:lspPkg::masterLow][31:0] lSubA, lSubB,
	input wire [lspPkg::numMasters-1:lspPkg::masterLow][31:0] lAddA, lAddB,
	// Shared RAM and operator unit
	output logic [lspPkg::bufAddrWidth-1:0] ramReadAddr,
	output logic [lspPkg::bufAddrWidth-1:0] ramWriteAddr,
	output logic [lspPkg::coefWidth-1:0] ramWriteData,
	output logic ramWriteEn,
	output logic [15:0] opSubA, opSubB,
	output logic [15:0] opAddA, opAddB,
	output logic [15:0] opShrVar1, opShrVar2,
	output logic [31:0] opLSubA, opLSubB,
	output logic [31:0] opLAddA, opLAddB
);

	import lspPkg::*;

	logic [numMasters-1:0] grantNext;
	logic [$clog2(numMasters)-1:0] pointer, pointerNext;	// Last master granted
	logic [$clog2(numMasters)-1:0] idx;
	logic found;

	//////////////////////////////
	// Round-robin pick

	always_comb
	begin
		grantNext = '0;
		pointerNext = pointer;
		idx = pointer;
		found = 1'b0;
		if (|(grant & request))
			grantNext = grant;	// Holder keeps the bus
		else
			for (int k = 0; k < numMasters; k++)
			begin
				idx = idx + 1'b1;	// Wraps, numMasters is a power of two
				if (request[idx] && !found)
				begin
					grantNext[idx] = 1'b1;
					pointerNext = idx;
					found = 1'b1;
				end
			end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			grant <= '0;
			pointer <= '0;
		end
		else
		begin
			grant <= grantNext;
			pointer <= pointerNext;
		end
	end

	//////////////////////////////
	// Operand mux, ungranted masters see zeros

	always_comb
	begin
		ramReadAddr = '0;
		ramWriteAddr = '0;
		ramWriteData = '0;
		ramWriteEn = 1'b0;
		opSubA = '0;
		opSubB = '0;
		opAddA = '0;
		opAddB = '0;
		opShrVar1 = '0;
		opShrVar2 = '0;
		opLSubA = '0;
		opLSubB = '0;
		opLAddA = '0;
		opLAddB = '0;
		for (int m = 0; m < numMasters; m++)
			if (grant[m])
			begin
				ramReadAddr = memReadAddr[m];
				ramWriteAddr = memWriteAddr[m];
				ramWriteData = memWriteData[m];
				ramWriteEn = memWriteEn[m];
			end
		for (int m = masterLow; m < numMasters; m++)	// AXI uses no operators
			if (grant[m])
			begin
				opSubA = subA[m];
				opSubB = subB[m];
				opAddA = addA[m];
				opAddB = addB[m];
				opShrVar1 = shrVar1[m];
				opShrVar2 = shrVar2[m];
				opLSubA = lSubA[m];
				opLSubB = lSubB[m];
				opLAddA = lAddA[m];
				opLAddB = lAddB[m];
			end
	end

endmodule

`default_nettype wire

/* rtl/lspBufferRam.sv */
`default_nettype none

module lspBufferRam (
	input wire clk,
	input wire [lspPkg::bufAddrWidth-1:0] readAddr,
	input wire [lspPkg::bufAddrWidth-1:0] writeAddr,
	input wire [lspPkg::coefWidth-1:0] writeData,
	input wire writeEn,
	output logic [lspPkg::coefWidth-1:0] readData
);

	import lspPkg::*;

	logic [coefWidth-1:0] mem [bufDepth];	// LSP coefficient buffer

	// Separate read and write ports, read is registered
	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
		readData <= mem[readAddr];	// Old word on same-address collision
	end

endmodule

`default_nettype wire

/* rtl/lspExpand.sv */
`default_nettype none

module lspExpand #(
	parameter int firstIndex = 1,
	parameter int lastIndex = 4
) (
	input wire clk,
	input wire reset,
	input wire start,
	input wire grant,
	input wire [lspPkg::coefWidth-1:0] gap,
	input wire [lspPkg::coefWidth-1:0] memIn,
	input wire [15:0] subIn,
	input wire [15:0] addIn,
	input wire [15:0] shrIn,
	input wire [31:0] lSubIn,
	input wire [31:0] lAddIn,
	output logic request,
	output logic done,
	output logic [lspPkg::bufAddrWidth-1:0] memReadAddr,
	output logic [lspPkg::bufAddrWidth-1:0] memWriteAddr,
	output logic [lspPkg::coefWidth-1:0] memOut,
	output logic memWriteEn,
	output logic [15:0] subOutA,
	output logic [15:0] subOutB,
	output logic [15:0] addOutA,
	output logic [15:0] addOutB,
	output logic [15:0] shrVar1Out,
	output logic [15:0] shrVar2Out,
	output logic [31:0] lSubOutA,
	output logic [31:0] lSubOutB,
	output logic [31:0] lAddOutA,
	output logic [31:0] lAddOutB
);

	import lspPkg::*;

	logic [2:0] state, nextState;
	logic [bufAddrWidth-1:0] j, nextJ;	// Pair index, runs one past lastIndex
	logic jLD, jReset;
	logic [coefWidth-1:0] bufPrev, bufCur;	// buf[j-1], buf[j]
	logic bufPrevLD, bufCurLD;
	logic [coefWidth-1:0] tmp, nextTmp;
	logic tmpLD;

	//////////////////////////////
	// Registers

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= engIdle;
		else
			state <= nextState;
	end

	always_ff @(posedge clk)
	begin
		if (reset || jReset)
			j <= bufAddrWidth'(firstIndex);
		else if (jLD)
			j <= nextJ;
	end

	// Data latches
	always_ff @(posedge clk)
	begin
		if (bufPrevLD)
			bufPrev <= memIn;
		if (bufCurLD)
			bufCur <= memIn;
		if (tmpLD)
			tmp <= nextTmp;
	end

	//////////////////////////////
	// Next state and shared port drive

	always_comb
	begin
		nextState = state;
		nextJ = j;
		nextTmp = tmp;
		jLD = 1'b0;
		jReset = 1'b0;
		bufPrevLD = 1'b0;
		bufCurLD = 1'b0;
		tmpLD = 1'b0;
		done = 1'b0;
		memReadAddr = '0;
		memWriteAddr = '0;
		memOut = '0;
		memWriteEn = 1'b0;
		subOutA = '0;
		subOutB = '0;
		addOutA = '0;
		addOutB = '0;
		shrVar1Out = '0;
		shrVar2Out = '0;
		lSubOutA = '0;
		lSubOutB = '0;
		lAddOutA = '0;
		lAddOutB = '0;

		case (state)
			engIdle:
			begin
				if (start)
				begin
					jReset = 1'b1;
					nextState = engLoopTest;
				end
			end
			// for (j = first; j <= last; j++), held here until granted
			engLoopTest:
			begin
				if (grant && j > bufAddrWidth'(lastIndex))
				begin
					done = 1'b1;
					nextState = engIdle;
				end
				else if (grant)
				begin
					subOutA = 16'(j);	// j - 1
					subOutB = 16'd1;
					memReadAddr = subIn[bufAddrWidth-1:0];
					nextState = engReadCur;
				end
			end
			engReadCur:
			begin
				bufPrevLD = 1'b1;	// buf[j-1] arrives
				memReadAddr = j;
				nextState = engCompute;
			end
			// diff = sub(buf[j-1], buf[j]); tmp = shr(add(diff, gap), 1)
			engCompute:
			begin
				bufCurLD = 1'b1;
				subOutA = bufPrev;
				subOutB = memIn;
				addOutA = subIn;
				addOutB = gap;
				shrVar1Out = addIn;	// Operators chain in one cycle
				shrVar2Out = 16'd1;
				nextTmp = shrIn;
				tmpLD = 1'b1;
				nextState = engWritePrev;
			end
			engWritePrev:
			begin
				if (!tmp[15])
				begin
					subOutA = bufPrev;	// buf[j-1] - tmp
					subOutB = tmp;
					lSubOutA = 32'(j);	// Address j - 1
					lSubOutB = 32'd1;
					memOut = subIn;
					memWriteAddr = lSubIn[bufAddrWidth-1:0];
					memWriteEn = 1'b1;
					nextState = engWriteCur;
				end
				else
				begin
					addOutA = 16'(j);	// Skip pair, j + 1
					addOutB = 16'd1;
					nextJ = addIn[bufAddrWidth-1:0];
					jLD = 1'b1;
					nextState = engLoopTest;
				end
			end
			engWriteCur:
			begin
				addOutA = bufCur;	// buf[j] + tmp
				addOutB = tmp;
				memOut = addIn;
				memWriteAddr = j;
				memWriteEn = 1'b1;
				lAddOutA = 32'(j);
				lAddOutB = 32'd1;
				nextJ = lAddIn[bufAddrWidth-1:0];
				jLD = 1'b1;
				nextState = engLoopTest;
			end
			default:
				nextState = engIdle;
		endcase
	end

	// Held from start, released with the done pulse
	assign request = (state != engIdle) && !done;

endmodule

`default_nettype wire

/* rtl/lspExpandTop.sv */
`default_nettype none

module lspExpandTop (
	input wire clk,
	input wire reset,
	input wire [6:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [31:0] wdata,
	input wire [3:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [6:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready
);

	import lspPkg::*;

	//////////////////////////////
	// Per-master buses, indexed by master number
	wire [numMasters-1:0] request, grant;
	wire [numMasters-1:0][bufAddrWidth-1:0] mReadAddr, mWriteAddr;
	wire [numMasters-1:0][coefWidth-1:0] mWriteData;
	wire [numMasters-1:0] mWriteEn;
	wire [numMasters-1:masterLow][15:0] subA, subB, addA, addB, shrVar1, shrVar2;
	wire [numMasters-1:masterLow][31:0] lSubA, lSubB, lAddA, lAddB;

	// Shared side of the arbiter
	wire [bufAddrWidth-1:0] ramReadAddr, ramWriteAddr;
	wire [coefWidth-1:0] ramWriteData, ramReadData;
	wire ramWriteEn;
	wire [15:0] opSubA, opSubB, opAddA, opAddB, opShrVar1, opShrVar2;
	wire [31:0] opLSubA, opLSubB, opLAddA, opLAddB;
	wire [15:0] subResult, addResult, shrResult;	// Broadcast to all engines
	wire [31:0] lSubResult, lAddResult;
	wire [coefWidth-1:0] gap;
	wire startLow, startHigh, startFull, doneLow, doneHigh, doneFull;

	axiLiteRegs regs (
		.clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid,
		.rready, .startLow, .startHigh, .startFull, .doneLow, .doneHigh, .doneFull, .gap,
		.request(request[masterAxi]), .grant(grant[masterAxi]),
		.memReadAddr(mReadAddr[masterAxi]), .memWriteAddr(mWriteAddr[masterAxi]),
		.memOut(mWriteData[masterAxi]), .memWriteEn(mWriteEn[masterAxi]),
		.memIn(ramReadData)
	);

	lspExpand #(.firstIndex(lowFirst), .lastIndex(lowLast)) lowEngine (
		.clk, .reset, .start(startLow), .grant(grant[masterLow]), .gap,
		.memIn(ramReadData), .subIn(subResult), .addIn(addResult), .shrIn(shrResult),
		.lSubIn(lSubResult), .lAddIn(lAddResult),
		.request(request[masterLow]), .done(doneLow),
		.memReadAddr(mReadAddr[masterLow]), .memWriteAddr(mWriteAddr[masterLow]),
		.memOut(mWriteData[masterLow]), .memWriteEn(mWriteEn[masterLow]),
		.subOutA(subA[masterLow]), .subOutB(subB[masterLow]),
		.addOutA(addA[masterLow]), .addOutB(addB[masterLow]),
		.shrVar1Out(shrVar1[masterLow]), .shrVar2Out(shrVar2[masterLow]),
		.lSubOutA(lSubA[masterLow]), .lSubOutB(lSubB[masterLow]),
		.lAddOutA(lAddA[masterLow]), .lAddOutB(lAddB[masterLow])
	);

	lspExpand #(.firstIndex(highFirst), .lastIndex(highLast)) highEngine (
		.clk, .reset, .start(startHigh), .grant(grant[masterHigh]), .gap,
		.memIn(ramReadData), .subIn(subResult), .addIn(addResult), .shrIn(shrResult),
		.lSubIn(lSubResult), .lAddIn(lAddResult),
		.request(request[masterHigh]), .done(doneHigh),
		.memReadAddr(mReadAddr[masterHigh]), .memWriteAddr(mWriteAddr[masterHigh]),
		.memOut(mWriteData[masterHigh]), .memWriteEn(mWriteEn[masterHigh]),
		.subOutA(subA[masterHigh]), .subOutB(subB[masterHigh]),
		.addOutA(addA[masterHigh]), .addOutB(addB[masterHigh]),
		.shrVar1Out(shrVar1[masterHigh]), .shrVar2Out(shrVar2[masterHigh]),
		.lSubOutA(lSubA[masterHigh]), .lSubOutB(lSubB[masterHigh]),
		.lAddOutA(lAddA[masterHigh]), .lAddOutB(lAddB[masterHigh])
	);

	lspExpand #(.firstIndex(fullFirst), .lastIndex(fullLast)) fullEngine (
		.clk, .reset, .start(startFull), .grant(grant[masterFull]), .gap,
		.memIn(ramReadData), .subIn(subResult), .addIn(addResult), .shrIn(shrResult),
		.lSubIn(lSubResult), .lAddIn(lAddResult),
		.request(request[masterFull]), .done(doneFull),
		.memReadAddr(mReadAddr[masterFull]), .memWriteAddr(mWriteAddr[masterFull]),
		.memOut(mWriteData[masterFull]), .memWriteEn(mWriteEn[masterFull]),
		.subOutA(subA[masterFull]), .subOutB(subB[masterFull]),
		.addOutA(addA[masterFull]), .addOutB(addB[masterFull]),
		.shrVar1Out(shrVar1[masterFull]), .shrVar2Out(shrVar2[masterFull]),
		.lSubOutA(lSubA[masterFull]), .lSubOutB(lSubB[masterFull]),
		.lAddOutA(lAddA[masterFull]), .lAddOutB(lAddB[masterFull])
	);

	busArbiter arbiter (
		.clk, .reset, .request, .grant,
		.memReadAddr(mReadAddr), .memWriteAddr(mWriteAddr),
		.memWriteData(mWriteData), .memWriteEn(mWriteEn),
		.subA, .subB, .addA, .addB, .shrVar1, .shrVar2, .lSubA, .lSubB, .lAddA, .lAddB,
		.ramReadAddr, .ramWriteAddr, .ramWriteData, .ramWriteEn,
		.opSubA, .opSubB, .opAddA, .opAddB, .opShrVar1, .opShrVar2,
		.opLSubA, .opLSubB, .opLAddA, .opLAddB
	);

	lspBufferRam bufferRam (
		.clk, .readAddr(ramReadAddr), .writeAddr(ramWriteAddr),
		.writeData(ramWriteData), .writeEn(ramWriteEn), .readData(ramReadData)
	);

	basicOps ops (
		.subA(opSubA), .subB(opSubB), .addA(opAddA), .addB(opAddB),
		.shrVar1(opShrVar1), .shrVar2(opShrVar2),
		.lSubA(opLSubA), .lSubB(opLSubB), .lAddA(opLAddA), .lAddB(opLAddB),
		.subResult, .addResult, .shrResult, .lSubResult, .lAddResult
	);

endmodule

`default_nettype wire

/* rtl/lspPkg.sv */
`default_nettype none

package lspPkg;

	//////////////////////////////
	// Buffer geometry
	localparam int bufDepth = 16;
	localparam int bufAddrWidth = 4;
	localparam int coefWidth = 16;

	// Pair index ranges, one per engine
	localparam int lowFirst = 1;	// Lsp_Expand_1
	localparam int lowLast = 4;
	localparam int highFirst = 5;	// Lsp_Expand_2
	localparam int highLast = 9;
	localparam int fullFirst = 1;	// Lsp_Expand_1_2
	localparam int fullLast = 9;

	// Arbiter masters, also bit positions in control and status
	localparam int numMasters = 4;
	localparam int masterAxi = 0;
	localparam int masterLow = 1;
	localparam int masterHigh = 2;
	localparam int masterFull = 3;

	//////////////////////////////
	// Register map, 7-bit byte address
	localparam logic [6:0] regBufBase = 7'h00;	// 16 words at 4-byte steps
	localparam logic [6:0] regControl = 7'h40;
	localparam logic [6:0] regGap = 7'h44;
	localparam logic [6:0] regStatus = 7'h48;
	localparam logic [15:0] defaultGap = 16'd10;

	// Engine FSM codes
	localparam logic [2:0] engIdle = 3'd0;
	localparam logic [2:0] engLoopTest = 3'd1;
	localparam logic [2:0] engReadCur = 3'd2;
	localparam logic [2:0] engCompute = 3'd3;
	localparam logic [2:0] engWritePrev = 3'd4;
	localparam logic [2:0] engWriteCur = 3'd5;

endpackage

`default_nettype wire

/* verification/lspExpandTb.sv */
`default_nettype none

module lspExpandTb;

	timeunit 1ns;
	timeprecision 100ps;

	import lspPkg::*;

	localparam int handshakeLimit = 200;	// Cycles per AXI wait
	localparam int pollLimit = 100;	// Status reads per done wait

	logic clk;
	logic reset;
	logic [6:0] awaddr;
	logic awvalid;
	wire awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	wire wready;
	wire [1:0] bresp;
	wire bvalid;
	logic bready;
	logic [6:0] araddr;
	logic arvalid;
	wire arready;
	wire [31:0] rdata;
	wire [1:0] rresp;
	wire rvalid;
	logic rready;

	int errorCount;
	int timeoutCount;
	int checkCount;
	logic [31:0] rngState;
	logic [15:0] model [16];	// Expected buffer contents
	logic [15:0] image [16];
	logic [15:0] orderA [16];	// Low then high
	logic [15:0] orderB [16];	// High then low
	logic [15:0] readBack [16];

	lspExpandTop UUT (
		.clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid,
		.rready
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	//////////////////////////////
	// Checks and reference model

	task automatic expectValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		assert (got === expected)
		else
		begin
			errorCount++;
			$display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got,
				expected);
		end
	endtask

	// xorshift32, state kept between calls
	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Clamp to the signed 16-bit range
	function automatic int saturate16(input int value);
		if (value > 32767)
			return 32767;
		else if (value < -32768)
			return -32768;
		else
			return value;
	endfunction

	// Pair expansion over first..last, sequential like the engines
	task automatic expandModel(input int first, input int last, input int gapValue);
		int prev;
		int cur;
		int diff;
		int tmp;
		for (int j = first; j <= last; j++)
		begin
			prev = $signed(model[j-1]);
			cur = $signed(model[j]);
			diff = saturate16(prev - cur);
			tmp = saturate16(diff + gapValue) >>> 1;
			if (tmp >= 0)	// Negative tmp leaves the pair alone
			begin
				model[j-1] = 16'(saturate16(prev - tmp));
				model[j] = 16'(saturate16(cur + tmp));
			end
		end
	endtask

	//////////////////////////////
	// AXI4-Lite master, called 1 ns after a rising edge

	task automatic writeWord(input logic [6:0] addr, input logic [31:0] data);
		int waited;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		waited = 0;
		@(negedge clk);	// Sample mid-cycle
		while (!(awready && wready) && waited < handshakeLimit)
		begin
			@(negedge clk);
			waited++;
		end
		assert (awready && wready)
		else
		begin
			timeoutCount++;
			$display("Timeout: write to 0x%02h was not accepted in %0d cycles", addr, waited);
		end
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!bvalid && waited < handshakeLimit)
		begin
			@(negedge clk);
			waited++;
		end
		assert (bvalid)
		else
		begin
			timeoutCount++;
			$display("Timeout: no write response for 0x%02h", addr);
		end
		expectValue("bresp", 32'(bresp), 32'h0);	// OKAY
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic readWord(input logic [6:0] addr, output logic [31:0] data);
		int waited;
		araddr = addr;
		arvalid = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!arready && waited < handshakeLimit)
		begin
			@(negedge clk);
			waited++;
		end
		assert (arready)
		else
		begin
			timeoutCount++;
			$display("Timeout: read of 0x%02h was not accepted in %0d cycles", addr, waited);
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		rready = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!rvalid && waited < handshakeLimit)
		begin
			@(negedge clk);
			waited++;
		end
		assert (rvalid)
		else
		begin
			timeoutCount++;
			$display("Timeout: no read data returned for 0x%02h", addr);
		end
		data = rdata;	// Stable at the falling edge
		expectValue("rresp", 32'(rresp), 32'h0);	// OKAY
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	//////////////////////////////
	// Buffer helpers

	task automatic loadBuffer();
		for (int i = 0; i < bufDepth; i++)
			writeWord(7'(regBufBase + 4 * i), 32'(model[i]));
	endtask

	task automatic compareBuffer(input string tag);
		logic [31:0] value;
		for (int i = 0; i < bufDepth; i++)
		begin
			readWord(7'(regBufBase + 4 * i), value);
			expectValue($sformatf("%s word %0d", tag, i), value, 32'(model[i]));
		end
	endtask

	// Poll status until a done bit shows up
	task automatic waitDone(input int bitPos);
		logic [31:0] status;
		int polls;
		status = '0;
		polls = 0;
		while (!status[bitPos] && polls < pollLimit)
		begin
			readWord(regStatus, status);
			polls++;
		end
		assert (status[bitPos])
		else
		begin
			timeoutCount++;
			$display("Timeout: done flag %0d never set after %0d status reads", bitPos, polls);
		end
	endtask

	//////////////////////////////
	// Test sequence

	initial
	begin
		logic [31:0] value;
		logic matchA;
		logic matchB;
		errorCount = 0;
		timeoutCount = 0;
		checkCount = 0;
		rngState = 32'hba32750a;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset values
		readWord(regStatus, value);
		expectValue("status after reset", value, 32'h0);
		readWord(regGap, value);
		expectValue("gap after reset", value, 32'd10);

		// Buffer window round trip
		for (int i = 0; i < bufDepth; i++)
			model[i] = 16'(nextRandom());
		loadBuffer();
		compareBuffer("window");

		// Low engine, default gap
		writeWord(regControl, 32'(1) << masterLow);
		waitDone(masterLow);
		expandModel(lowFirst, lowLast, 10);
		compareBuffer("low");
		writeWord(regStatus, 32'he);	// Clear all done flags
		readWord(regStatus, value);
		expectValue("status after clear", value, 32'h0);

		// Full engine on edge cases, gap 5
		writeWord(regGap, 32'd5);
		readWord(regGap, value);
		expectValue("gap", value, 32'd5);
		model[0] = 16'h8000;	// Equal at the minimum
		model[1] = 16'h8000;
		model[2] = 16'd100;	// Negative tmp
		model[3] = 16'd103;	// Crowded
		model[4] = 16'h7fff;	// Equal at the maximum
		model[5] = 16'h7fff;
		model[6] = 16'h8000;	// Reversed, diff saturates
		model[7] = 16'hbffa;	// -16390
		model[8] = 16'd500;
		model[9] = 16'd500;
		for (int i = 10; i < bufDepth; i++)
			model[i] = 16'(nextRandom());
		loadBuffer();
		writeWord(regControl, 32'(1) << masterFull);
		waitDone(masterFull);
		expandModel(fullFirst, fullLast, 5);
		compareBuffer("full");
		writeWord(regStatus, 32'he);

		//////////////////////////////
		// Two engines contend with an AXI read
		for (int i = 0; i < bufDepth; i++)
		begin
			image[i] = 16'(nextRandom());
			model[i] = image[i];
		end
		loadBuffer();
		expandModel(lowFirst, lowLast, 5);
		expandModel(highFirst, highLast, 5);
		for (int i = 0; i < bufDepth; i++)
		begin
			orderA[i] = model[i];
			model[i] = image[i];
		end
		expandModel(highFirst, highLast, 5);
		expandModel(lowFirst, lowLast, 5);
		for (int i = 0; i < bufDepth; i++)
			orderB[i] = model[i];

		writeWord(regControl, (32'(1) << masterLow) | (32'(1) << masterHigh));
		readWord(regBufBase, value);	// Stalls behind both engines
		expectValue("contended read of word 0", value, 32'(orderA[0]));
		readWord(regStatus, value);
		expectValue("status after contended read", value, 32'h6);	// Done set, not busy

		matchA = 1'b1;
		matchB = 1'b1;
		for (int i = 0; i < bufDepth; i++)
		begin
			readWord(7'(regBufBase + 4 * i), value);
			readBack[i] = value[15:0];
			if (value !== 32'(orderA[i]))
				matchA = 1'b0;
			if (value !== 32'(orderB[i]))
				matchB = 1'b0;
		end
		checkCount++;
		assert (matchA || matchB)
		else
		begin
			errorCount++;
			for (int i = 0; i < bufDepth; i++)
				if (readBack[i] !== orderA[i])
					$display("** Error at %0t ns: word %0d is 0x%04h, expected 0x%04h or 0x%04h",
						$time, i, readBack[i], orderA[i], orderB[i]);
		end

		// Write one to clear
		writeWord(regStatus, 32'h6);
		readWord(regStatus, value);
		expectValue("status after done clear", value, 32'h0);

		$display("Checks run: %0d, value errors: %0d, timeouts: %0d", checkCount, errorCount,
			timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
